//--- hdl/apb_decoder.sv
module apb_decoder (
  input  logic                                            clock,
  input  logic                                            reset,
  input  logic [periph_pkg::ADDR_W-1:0]                   paddr_i,
  input  logic                                            psel_i,
  input  logic                                            penable_i,
  input  logic [periph_pkg::NUM_DEVICES-1:0][periph_pkg::DATA_W-1:0] dev_rdata_i,
  output logic [periph_pkg::NUM_DEVICES-1:0]              dev_sel_o,
  output logic [periph_pkg::OFFSET_W-1:0]                 reg_offset_o,
  output logic [periph_pkg::DATA_W-1:0]                   prdata_o,
  output logic                                            pready_o,
  output logic                                            pslverr_o
);

  import periph_pkg::*;

  bus_addr_u addr;
  logic      base_hit;
  logic      access;

  // Raw APB address seen through the field view
  assign addr.raw = paddr_i;

  assign base_hit = (addr.fields.base == PERIPH_BASE);

  // Access phase of a transfer
  assign access = psel_i & penable_i;

  // ----------------------------------------------------------
  // Device select
  // ----------------------------------------------------------

  // One-hot select held through setup and access phases
  always_comb begin
    dev_sel_o = '0;
    for (int i = 0; i < NUM_DEVICES; i++) begin
      if (psel_i && base_hit && (addr.fields.dev_idx == 4'(i))) begin
        dev_sel_o[i] = 1'b1;
      end
    end
  end

  // Devices only see the offset inside their own region
  assign reg_offset_o = addr.fields.offset;

  // ----------------------------------------------------------
  // Read data and response
  // ----------------------------------------------------------

  // No device selected leaves the read word at zero
  always_comb begin
    prdata_o = '0;
    if (access) begin
      for (int i = 0; i < NUM_DEVICES; i++) begin
        if (dev_sel_o[i]) begin
          prdata_o = prdata_o | dev_rdata_i[i];
        end
      end
    end
  end

  // Zero wait states
  assign pready_o = access;

  // Unmapped base or device index
  assign pslverr_o = access & ~(|dev_sel_o);

endmodule

//--- hdl/gpio_port.sv
module gpio_port #(
  parameter int GPIO_WIDTH = 4
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              sel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [periph_pkg::OFFSET_W-1:0]   reg_offset_i,
  input  logic [periph_pkg::DATA_W-1:0]     pwdata_i,
  input  logic [GPIO_WIDTH-1:0]             gpio_in_i,
  output logic [periph_pkg::DATA_W-1:0]     rdata_o,
  output logic [GPIO_WIDTH-1:0]             gpio_sync_o,
  output logic [GPIO_WIDTH-1:0]             gpio_out_o,
  output logic [GPIO_WIDTH-1:0]             gpio_oe_o
);

  import periph_pkg::*;

  logic                  wr_en;
  logic [GPIO_WIDTH-1:0] meta_q;

  assign wr_en = sel_i & penable_i & pwrite_i;

  // Two-flop synchronizer on the input pins
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      meta_q      <= '0;
      gpio_sync_o <= '0;
    end else begin
      meta_q      <= gpio_in_i;
      gpio_sync_o <= meta_q;
    end
  end

  // Output and output-enable registers
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      gpio_out_o <= '0;
      gpio_oe_o  <= '0;
    end else if (wr_en) begin
      if (reg_offset_i == GPIO_OUT_OFS) begin
        gpio_out_o <= pwdata_i[GPIO_WIDTH-1:0];
      end
      if (reg_offset_i == GPIO_OE_OFS) begin
        gpio_oe_o <= pwdata_i[GPIO_WIDTH-1:0];
      end
    end
  end

  // Read data zero-extended to the bus width
  always_comb begin
    case (reg_offset_i)
      GPIO_IN_OFS:  rdata_o = DATA_W'(gpio_sync_o);
      GPIO_OUT_OFS: rdata_o = DATA_W'(gpio_out_o);
      GPIO_OE_OFS:  rdata_o = DATA_W'(gpio_oe_o);
      default:      rdata_o = '0;
    endcase
  end

endmodule

//--- hdl/irq_ctrl.sv
module irq_ctrl #(
  parameter int GPIO_WIDTH = 4
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              sel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [periph_pkg::OFFSET_W-1:0]   reg_offset_i,
  input  logic [periph_pkg::DATA_W-1:0]     pwdata_i,
  input  logic                              timer_irq_i,
  input  logic [GPIO_WIDTH-1:0]             gpio_sync_i,
  output logic [periph_pkg::DATA_W-1:0]     rdata_o,
  output logic                              irq_o
);

  import periph_pkg::*;

  // Timer in bit 0, GPIO inputs above it
  localparam int NUM_SRC = GPIO_WIDTH + 1;

  logic               wr_en;
  logic [NUM_SRC-1:0] src;
  logic [NUM_SRC-1:0] src_q;
  logic [NUM_SRC-1:0] rise;
  logic [NUM_SRC-1:0] clr;
  logic [NUM_SRC-1:0] pending;
  logic [NUM_SRC-1:0] enable;

  assign wr_en = sel_i & penable_i & pwrite_i;
  assign src   = {gpio_sync_i, timer_irq_i};
  assign rise  = src & ~src_q;
  assign clr   = (wr_en && (reg_offset_i == IRQ_PEND_OFS)) ? pwdata_i[NUM_SRC-1:0] : '0;

  // A new edge beats a clear in the same cycle
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      src_q   <= '0;
      pending <= '0;
    end else begin
      src_q   <= src;
      pending <= (pending & ~clr) | rise;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      enable <= '0;
    end else if (wr_en && (reg_offset_i == IRQ_EN_OFS)) begin
      enable <= pwdata_i[NUM_SRC-1:0];
    end
  end

  // Combined request
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= |(pending & enable);
    end
  end

  always_comb begin
    case (reg_offset_i)
      IRQ_PEND_OFS: rdata_o = DATA_W'(pending);
      IRQ_EN_OFS:   rdata_o = DATA_W'(enable);
      default:      rdata_o = '0;
    endcase
  end

endmodule

//--- hdl/mtimer.sv
module mtimer (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              sel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [periph_pkg::OFFSET_W-1:0]   reg_offset_i,
  input  logic [periph_pkg::DATA_W-1:0]     pwdata_i,
  output logic [periph_pkg::DATA_W-1:0]     rdata_o,
  output logic                              timer_irq_o
);

  import periph_pkg::*;

  logic        wr_en;
  logic        count_en;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;

  assign wr_en = sel_i & penable_i & pwrite_i;

  // ----------------------------------------------------------
  // Control register
  // ----------------------------------------------------------

  // Bit 0 starts and stops the counter
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      count_en <= 1'b0;
    end else if (wr_en && (reg_offset_i == MT_CTRL_OFS)) begin
      count_en <= pwdata_i[0];
    end
  end

  // ----------------------------------------------------------
  // mtime counter
  // ----------------------------------------------------------

  // A write to either half takes priority over counting
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtime <= '0;
    end else if (wr_en && (reg_offset_i == MT_TIME_LO_OFS)) begin
      mtime <= {mtime[63:32], pwdata_i};
    end else if (wr_en && (reg_offset_i == MT_TIME_HI_OFS)) begin
      mtime <= {pwdata_i, mtime[31:0]};
    end else if (count_en) begin
      mtime <= mtime + 64'd1;
    end
  end

  // ----------------------------------------------------------
  // mtimecmp and interrupt
  // ----------------------------------------------------------

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtimecmp <= '1;
    end else if (wr_en) begin
      if (reg_offset_i == MT_CMP_LO_OFS) begin
        mtimecmp[31:0] <= pwdata_i;
      end
      if (reg_offset_i == MT_CMP_HI_OFS) begin
        mtimecmp[63:32] <= pwdata_i;
      end
    end
  end

  // Compare result registered, so the level follows mtime by one cycle
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      timer_irq_o <= 1'b0;
    end else begin
      timer_irq_o <= (mtime >= mtimecmp);
    end
  end

  always_comb begin
    case (reg_offset_i)
      MT_CTRL_OFS:    rdata_o = DATA_W'(count_en);
      MT_TIME_LO_OFS: rdata_o = mtime[31:0];
      MT_TIME_HI_OFS: rdata_o = mtime[63:32];
      MT_CMP_LO_OFS:  rdata_o = mtimecmp[31:0];
      MT_CMP_HI_OFS:  rdata_o = mtimecmp[63:32];
      default:        rdata_o = '0;
    endcase
  end

endmodule

//--- hdl/periph_pkg.sv
package periph_pkg;

  // ----------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int OFFSET_W = 8;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------
  localparam int NUM_DEVICES = 3;
  localparam int DEV_GPIO    = 0;
  localparam int DEV_MTIMER  = 1;
  localparam int DEV_IRQ     = 2;

  // Upper 12 address bits shared by all devices
  localparam logic [11:0] PERIPH_BASE = 12'h800;

  // GPIO registers
  localparam logic [OFFSET_W-1:0] GPIO_IN_OFS  = 8'h00;
  localparam logic [OFFSET_W-1:0] GPIO_OUT_OFS = 8'h04;
  localparam logic [OFFSET_W-1:0] GPIO_OE_OFS  = 8'h08;

  // Machine timer registers
  localparam logic [OFFSET_W-1:0] MT_CTRL_OFS    = 8'h00;
  localparam logic [OFFSET_W-1:0] MT_TIME_LO_OFS = 8'h04;
  localparam logic [OFFSET_W-1:0] MT_TIME_HI_OFS = 8'h08;
  localparam logic [OFFSET_W-1:0] MT_CMP_LO_OFS  = 8'h0C;
  localparam logic [OFFSET_W-1:0] MT_CMP_HI_OFS  = 8'h10;

  // Interrupt block registers
  localparam logic [OFFSET_W-1:0] IRQ_PEND_OFS = 8'h00;
  localparam logic [OFFSET_W-1:0] IRQ_EN_OFS   = 8'h04;

  // Address word split into base, device index and register offset
  typedef struct packed {
    logic [11:0]         base;
    logic [3:0]          dev_idx;
    logic [7:0]          rsvd;
    logic [OFFSET_W-1:0] offset;
  } bus_addr_fields_t;

  typedef union packed {
    logic [ADDR_W-1:0] raw;
    bus_addr_fields_t  fields;
  } bus_addr_u;

endpackage

//--- hdl/periph_top.sv
module periph_top #(
  parameter int GPIO_WIDTH = 4
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [periph_pkg::ADDR_W-1:0]   paddr_i,
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [periph_pkg::DATA_W-1:0]   pwdata_i,
  input  logic [GPIO_WIDTH-1:0]           gpio_in_i,
  output logic [periph_pkg::DATA_W-1:0]   prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  output logic [GPIO_WIDTH-1:0]           gpio_out_o,
  output logic [GPIO_WIDTH-1:0]           gpio_oe_o,
  output logic                            irq_o
);

  import periph_pkg::*;

  logic [NUM_DEVICES-1:0]             dev_sel;
  logic [OFFSET_W-1:0]                reg_offset;
  logic [NUM_DEVICES-1:0][DATA_W-1:0] dev_rdata;
  logic [GPIO_WIDTH-1:0]              gpio_sync;
  logic                               timer_irq;

  // ----------------------------------------------------------
  // APB front end
  // ----------------------------------------------------------
  apb_decoder u_apb_decoder (
    .clock        (clock),
    .reset        (reset),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .dev_rdata_i  (dev_rdata),
    .dev_sel_o    (dev_sel),
    .reg_offset_o (reg_offset),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o)
  );

  // ----------------------------------------------------------
  // Devices
  // ----------------------------------------------------------
  gpio_port #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) u_gpio_port (
    .clock        (clock),
    .reset        (reset),
    .sel_i        (dev_sel[DEV_GPIO]),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .reg_offset_i (reg_offset),
    .pwdata_i     (pwdata_i),
    .gpio_in_i    (gpio_in_i),
    .rdata_o      (dev_rdata[DEV_GPIO]),
    .gpio_sync_o  (gpio_sync),
    .gpio_out_o   (gpio_out_o),
    .gpio_oe_o    (gpio_oe_o)
  );

  mtimer u_mtimer (
    .clock        (clock),
    .reset        (reset),
    .sel_i        (dev_sel[DEV_MTIMER]),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .reg_offset_i (reg_offset),
    .pwdata_i     (pwdata_i),
    .rdata_o      (dev_rdata[DEV_MTIMER]),
    .timer_irq_o  (timer_irq)
  );

  irq_ctrl #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) u_irq_ctrl (
    .clock        (clock),
    .reset        (reset),
    .sel_i        (dev_sel[DEV_IRQ]),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .reg_offset_i (reg_offset),
    .pwdata_i     (pwdata_i),
    .timer_irq_i  (timer_irq),
    .gpio_sync_i  (gpio_sync),
    .rdata_o      (dev_rdata[DEV_IRQ]),
    .irq_o        (irq_o)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --top-module tb_periph_top -f sources.f > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_periph_top > sim.log 2>&1
cat sim.log
grep -q "Simulation PASSED" sim.log \
  && echo "Run passed" \
  || { echo "Run failed, see sim.log"; exit 1; }

//--- sources.f
hdl/periph_pkg.sv
hdl/apb_decoder.sv
hdl/gpio_port.sv
hdl/mtimer.sv
hdl/irq_ctrl.sv
hdl/periph_top.sv
tests/tb_clock_gen.sv
tests/tb_periph_top.sv

//--- tests/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // Release away from both clock edges
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #(PERIOD / 4);
    reset = 1'b0;
  end

endmodule

//--- tests/tb_periph_top.sv
module tb_periph_top;

  import periph_pkg::*;

  localparam int GPIO_WIDTH    = 4;
  localparam int READY_TIMEOUT = 20;
  localparam int RESET_TIMEOUT = 100;
  localparam int IRQ_TIMEOUT   = 100;

  logic                  clock;
  logic                  reset;
  logic [ADDR_W-1:0]     paddr_i;
  logic                  psel_i;
  logic                  penable_i;
  logic                  pwrite_i;
  logic [DATA_W-1:0]     pwdata_i;
  logic [GPIO_WIDTH-1:0] gpio_in_i;
  logic [DATA_W-1:0]     prdata_o;
  logic                  pready_o;
  logic                  pslverr_o;
  logic [GPIO_WIDTH-1:0] gpio_out_o;
  logic [GPIO_WIDTH-1:0] gpio_oe_o;
  logic                  irq_o;

  int checks;
  int errors;

  // Register model
  logic [GPIO_WIDTH-1:0] out_m;
  logic [GPIO_WIDTH-1:0] oe_m;
  logic [63:0]           cmp_m;
  logic [GPIO_WIDTH:0]   en_m;
  logic [GPIO_WIDTH:0]   pend_m;

  tb_clock_gen #(
    .PERIOD       (20),
    .RESET_CYCLES (16)
  ) clk_gen_i (
    .clock (clock),
    .reset (reset)
  );

  periph_top #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) dut_i (
    .clock      (clock),
    .reset      (reset),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .gpio_in_i  (gpio_in_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .irq_o      (irq_o)
  );

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task check(input logic [63:0] actual, input logic [63:0] expected, input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
    end
  endtask

  task abort_on_timeout(input string what);
    $display("Timeout: %s did not happen in time", what);
    $display("Simulation FAILED");
    $finish;
  endtask

  function automatic logic [31:0] reg_addr(input int dev, input logic [7:0] ofs);
    return {PERIPH_BASE, 4'(dev), 8'h00, ofs};
  endfunction

  // Outputs are sampled a little after the falling edge
  task wait_ready(input string what);
    int cnt;
    cnt = 0;
    #2;
    while (!pready_o) begin
      if (cnt >= READY_TIMEOUT) abort_on_timeout(what);
      @(negedge clock);
      #2;
      cnt++;
    end
  endtask

  task write_reg(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clock);
    paddr_i  = addr;
    pwdata_i = data;
    pwrite_i = 1'b1;
    psel_i   = 1'b1;
    @(negedge clock);
    penable_i = 1'b1;
    wait_ready("pready on a write");
    @(negedge clock);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task fetch_reg(input logic [31:0] addr, output logic [31:0] data, output logic err);
    @(negedge clock);
    paddr_i  = addr;
    pwrite_i = 1'b0;
    psel_i   = 1'b1;
    @(negedge clock);
    penable_i = 1'b1;
    wait_ready("pready on a read");
    data = prdata_o;
    err  = pslverr_o;
    @(negedge clock);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  // Rising pins become pending bits once synchronized
  task set_gpio_in(input logic [GPIO_WIDTH-1:0] value);
    @(negedge clock);
    pend_m    = pend_m | {value & ~gpio_in_i, 1'b0};
    gpio_in_i = value;
  endtask

  task verify_registers(input string where);
    logic [31:0] rd;
    logic        err;
    check(64'(gpio_out_o), 64'(out_m), {where, ": gpio_out_o"});
    check(64'(gpio_oe_o), 64'(oe_m), {where, ": gpio_oe_o"});
    fetch_reg(reg_addr(DEV_GPIO, GPIO_OUT_OFS), rd, err);
    check(64'(rd), 64'(out_m), {where, ": GPIO out readback"});
    fetch_reg(reg_addr(DEV_GPIO, GPIO_OE_OFS), rd, err);
    check(64'(rd), 64'(oe_m), {where, ": GPIO oe readback"});
    fetch_reg(reg_addr(DEV_MTIMER, MT_CMP_LO_OFS), rd, err);
    check(64'(rd), 64'(cmp_m[31:0]), {where, ": mtimecmp low"});
    fetch_reg(reg_addr(DEV_MTIMER, MT_CMP_HI_OFS), rd, err);
    check(64'(rd), 64'(cmp_m[63:32]), {where, ": mtimecmp high"});
    fetch_reg(reg_addr(DEV_IRQ, IRQ_EN_OFS), rd, err);
    check(64'(rd), 64'(en_m), {where, ": irq enable"});
    fetch_reg(reg_addr(DEV_IRQ, IRQ_PEND_OFS), rd, err);
    check(64'(rd), 64'(pend_m), {where, ": irq pending"});
    check(64'(err), 64'(0), {where, ": pslverr on irq read"});
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin : main_seq
    logic [31:0] rd;
    logic [31:0] wd;
    logic [31:0] prev;
    logic [31:0] t_lo;
    logic [31:0] t_hi;
    logic [11:0] base;
    logic [3:0]  idx;
    logic        err;
    int          cnt;

    paddr_i   = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    pwdata_i  = '0;
    gpio_in_i = '0;
    checks    = 0;
    errors    = 0;
    out_m     = '0;
    oe_m      = '0;
    cmp_m     = '1;
    en_m      = '0;
    pend_m    = '0;
    void'($urandom(32'h30d9_c5b2));

    cnt = 0;
    while (reset !== 1'b0) begin
      if (cnt >= RESET_TIMEOUT) abort_on_timeout("reset release");
      @(negedge clock);
      cnt++;
    end

    // Reset values
    check(64'(irq_o), 64'(0), "irq_o after reset");
    fetch_reg(reg_addr(DEV_MTIMER, MT_CTRL_OFS), rd, err);
    check(64'(rd), 64'(0), "timer control after reset");
    check(64'(err), 64'(0), "pslverr on timer read");
    verify_registers("reset");

    // GPIO outputs and inputs
    for (int i = 0; i < 8; i++) begin
      wd    = $urandom;
      out_m = wd[GPIO_WIDTH-1:0];
      write_reg(reg_addr(DEV_GPIO, GPIO_OUT_OFS), wd);
      wd   = $urandom;
      oe_m = wd[GPIO_WIDTH-1:0];
      write_reg(reg_addr(DEV_GPIO, GPIO_OE_OFS), wd);
      verify_registers("gpio write");
      set_gpio_in(GPIO_WIDTH'($urandom));
      repeat (3) @(negedge clock);
      fetch_reg(reg_addr(DEV_GPIO, GPIO_IN_OFS), rd, err);
      check(64'(rd), 64'(gpio_in_i), "GPIO input readback");
      check(64'(err), 64'(0), "pslverr on GPIO read");
    end

    // Unmapped base or device index
    for (int i = 0; i < 10; i++) begin
      base = (i % 2 == 0) ? 12'($urandom_range(0, 4095)) : PERIPH_BASE;
      if (base == PERIPH_BASE && i % 2 == 0) base = 12'h801;
      idx = (i % 2 == 0) ? 4'($urandom_range(0, 2)) : 4'($urandom_range(3, 15));
      wd  = {base, idx, 8'($urandom), 8'($urandom_range(0, 4) * 4)};
      fetch_reg(wd, rd, err);
      check(64'(err), 64'(1), "pslverr on unmapped read");
      check(64'(rd), 64'(0), "read data on unmapped read");
      write_reg(wd, $urandom);
      verify_registers("unmapped write");
    end

    // Timer stopped, then running
    t_lo = $urandom & 32'h0fff_ffff;
    t_hi = $urandom & 32'h0000_ffff;
    write_reg(reg_addr(DEV_MTIMER, MT_TIME_LO_OFS), t_lo);
    write_reg(reg_addr(DEV_MTIMER, MT_TIME_HI_OFS), t_hi);
    for (int i = 0; i < 3; i++) begin
      fetch_reg(reg_addr(DEV_MTIMER, MT_TIME_LO_OFS), rd, err);
      check(64'(rd), 64'(t_lo), "stopped mtime low");
      fetch_reg(reg_addr(DEV_MTIMER, MT_TIME_HI_OFS), rd, err);
      check(64'(rd), 64'(t_hi), "stopped mtime high");
    end
    write_reg(reg_addr(DEV_MTIMER, MT_CTRL_OFS), 32'h1);
    fetch_reg(reg_addr(DEV_MTIMER, MT_TIME_LO_OFS), prev, err);
    for (int i = 0; i < 5; i++) begin
      fetch_reg(reg_addr(DEV_MTIMER, MT_TIME_LO_OFS), rd, err);
      check(64'(rd > prev), 64'(1), "running mtime increases");
      prev = rd;
    end
    // High half first so the compare never passes early
    cmp_m = {t_hi, prev + 32'd40};
    write_reg(reg_addr(DEV_MTIMER, MT_CMP_HI_OFS), cmp_m[63:32]);
    write_reg(reg_addr(DEV_MTIMER, MT_CMP_LO_OFS), cmp_m[31:0]);
    cnt = 0;
    fetch_reg(reg_addr(DEV_IRQ, IRQ_PEND_OFS), rd, err);
    while (!rd[0]) begin
      if (cnt >= IRQ_TIMEOUT) abort_on_timeout("timer interrupt pending");
      fetch_reg(reg_addr(DEV_IRQ, IRQ_PEND_OFS), rd, err);
      cnt++;
    end
    pend_m[0] = 1'b1;
    write_reg(reg_addr(DEV_MTIMER, MT_CTRL_OFS), 32'h0);
    verify_registers("timer");

    // GPIO edges, enable and clear
    for (int i = 0; i < 10; i++) begin
      set_gpio_in(GPIO_WIDTH'($urandom));
      repeat (4) @(negedge clock);
      fetch_reg(reg_addr(DEV_IRQ, IRQ_PEND_OFS), rd, err);
      check(64'(rd), 64'(pend_m), "pending after edges");
      wd   = $urandom;
      en_m = wd[GPIO_WIDTH:0];
      write_reg(reg_addr(DEV_IRQ, IRQ_EN_OFS), wd);
      repeat (2) @(negedge clock);
      check(64'(irq_o), 64'(|(pend_m & en_m)), "irq_o after enable");
      wd     = $urandom;
      pend_m = pend_m & ~wd[GPIO_WIDTH:0];
      write_reg(reg_addr(DEV_IRQ, IRQ_PEND_OFS), wd);
      fetch_reg(reg_addr(DEV_IRQ, IRQ_PEND_OFS), rd, err);
      check(64'(rd), 64'(pend_m), "pending after clear");
      repeat (2) @(negedge clock);
      check(64'(irq_o), 64'(|(pend_m & en_m)), "irq_o after clear");
    end
    verify_registers("irq");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
